// ==== mips_isa_pkg.sv ====
`default_nettype none

package mips_isa_pkg;

	localparam int WORD_W = 32;
	localparam int REG_W  = 5;

	typedef logic [WORD_W-1:0] word_t;
	typedef logic [REG_W-1:0]  reg_addr_t;

	localparam int OPCODE_POS = 26;
	localparam int OPCODE_W   = 6;
	localparam int RS_POS     = 21;
	localparam int RT_POS     = 16;
	localparam int RD_POS     = 11;
	localparam int SHAMT_POS  = 6;
	localparam int FUNCT_POS  = 0;
	localparam int FUNCT_W    = 6;
	localparam int IMM_POS    = 0;
	localparam int IMM_W      = 16;
	localparam int INDEX_POS  = 0;
	localparam int INDEX_W    = 26;

	localparam reg_addr_t LINK_REG = 5'd31; // ra

	localparam logic [OPCODE_W-1:0] OP_SPECIAL = 6'b000000;
	localparam logic [OPCODE_W-1:0] OP_REGIMM  = 6'b000001;
	localparam logic [OPCODE_W-1:0] OP_J       = 6'b000010;
	localparam logic [OPCODE_W-1:0] OP_JAL     = 6'b000011;
	localparam logic [OPCODE_W-1:0] OP_BEQ     = 6'b000100;
	localparam logic [OPCODE_W-1:0] OP_BNE     = 6'b000101;
	localparam logic [OPCODE_W-1:0] OP_BLEZ    = 6'b000110;
	localparam logic [OPCODE_W-1:0] OP_BGTZ    = 6'b000111;
	localparam logic [OPCODE_W-1:0] OP_ADDI    = 6'b001000;
	localparam logic [OPCODE_W-1:0] OP_ADDIU   = 6'b001001;
	localparam logic [OPCODE_W-1:0] OP_SLTI    = 6'b001010;
	localparam logic [OPCODE_W-1:0] OP_SLTIU   = 6'b001011;
	localparam logic [OPCODE_W-1:0] OP_ANDI    = 6'b001100;
	localparam logic [OPCODE_W-1:0] OP_ORI     = 6'b001101;
	localparam logic [OPCODE_W-1:0] OP_XORI    = 6'b001110;
	localparam logic [OPCODE_W-1:0] OP_LUI     = 6'b001111;
	localparam logic [OPCODE_W-1:0] OP_LW      = 6'b100011;
	localparam logic [OPCODE_W-1:0] OP_SW      = 6'b101011;

	localparam logic [FUNCT_W-1:0] FN_SLL  = 6'b000000;
	localparam logic [FUNCT_W-1:0] FN_SRL  = 6'b000010;
	localparam logic [FUNCT_W-1:0] FN_SRA  = 6'b000011;
	localparam logic [FUNCT_W-1:0] FN_SLLV = 6'b000100;
	localparam logic [FUNCT_W-1:0] FN_SRLV = 6'b000110;
	localparam logic [FUNCT_W-1:0] FN_SRAV = 6'b000111;
	localparam logic [FUNCT_W-1:0] FN_JR   = 6'b001000;
	localparam logic [FUNCT_W-1:0] FN_JALR = 6'b001001;
	localparam logic [FUNCT_W-1:0] FN_ADD  = 6'b100000;
	localparam logic [FUNCT_W-1:0] FN_ADDU = 6'b100001;
	localparam logic [FUNCT_W-1:0] FN_SUB  = 6'b100010;
	localparam logic [FUNCT_W-1:0] FN_SUBU = 6'b100011;
	localparam logic [FUNCT_W-1:0] FN_AND  = 6'b100100;
	localparam logic [FUNCT_W-1:0] FN_OR   = 6'b100101;
	localparam logic [FUNCT_W-1:0] FN_XOR  = 6'b100110;
	localparam logic [FUNCT_W-1:0] FN_NOR  = 6'b100111;
	localparam logic [FUNCT_W-1:0] FN_SLT  = 6'b101010;
	localparam logic [FUNCT_W-1:0] FN_SLTU = 6'b101011;

	localparam reg_addr_t RI_BLTZ   = 5'b00000; // rt field of regimm
	localparam reg_addr_t RI_BGEZ   = 5'b00001;
	localparam reg_addr_t RI_BLTZAL = 5'b10000;
	localparam reg_addr_t RI_BGEZAL = 5'b10001;

endpackage

`default_nettype wire

// ==== id_pkg.sv ====
`default_nettype none

package id_pkg;

	typedef enum logic [7:0] {
		ALU_NOP    = 8'b0000_0000,
		ALU_AND    = 8'b0010_0100,
		ALU_OR     = 8'b0010_0101,
		ALU_XOR    = 8'b0010_0110,
		ALU_NOR    = 8'b0010_0111,
		ALU_SLL    = 8'b0111_1100, // also sllv
		ALU_SRL    = 8'b0000_0010,
		ALU_SRA    = 8'b0000_0011,
		ALU_SLT    = 8'b0010_1010,
		ALU_SLTU   = 8'b0010_1011,
		ALU_ADD    = 8'b0010_0000,
		ALU_ADDU   = 8'b0010_0001,
		ALU_SUB    = 8'b0010_0010,
		ALU_SUBU   = 8'b0010_0011,
		ALU_ADDI   = 8'b0101_0101,
		ALU_ADDIU  = 8'b0101_0110,
		ALU_J      = 8'b0100_1111,
		ALU_JAL    = 8'b0101_0000,
		ALU_JR     = 8'b0000_1000,
		ALU_JALR   = 8'b0000_1001,
		ALU_BEQ    = 8'b0101_0001,
		ALU_BNE    = 8'b0101_0010,
		ALU_BLEZ   = 8'b0101_0011,
		ALU_BGTZ   = 8'b0101_0100,
		ALU_BLTZ   = 8'b0100_0000,
		ALU_BGEZ   = 8'b0100_0001,
		ALU_BLTZAL = 8'b0100_1010,
		ALU_BGEZAL = 8'b0100_1011,
		ALU_LW     = 8'b1110_0011,
		ALU_SW     = 8'b1110_1011
	} alu_op_e;

	typedef enum logic [2:0] {
		SEL_NOP         = 3'b000,
		SEL_LOGIC       = 3'b001,
		SEL_SHIFT       = 3'b010,
		SEL_ARITH       = 3'b100,
		SEL_JUMP_BRANCH = 3'b110,
		SEL_LOAD_STORE  = 3'b111
	} alu_sel_e;

	function automatic logic is_load(alu_op_e op);
		return op == ALU_LW;
	endfunction

endpackage

`default_nettype wire

// ==== inst_decoder.sv ====
`default_nettype none

module inst_decoder (
	input  var mips_isa_pkg::word_t     inst_i,
	output id_pkg::alu_op_e             aluop_o,
	output id_pkg::alu_sel_e            alusel_o,
	output logic                        reg1_read_o,
	output logic                        reg2_read_o,
	output logic                        wreg_o,
	output logic                        illegal_o,
	output mips_isa_pkg::reg_addr_t     wd_o,
	output mips_isa_pkg::word_t         imm_o
);
	import mips_isa_pkg::*;
	import id_pkg::*;

	logic [OPCODE_W-1:0] opcode;
	logic [FUNCT_W-1:0]  funct;
	reg_addr_t           rs;
	reg_addr_t           rt;
	reg_addr_t           rd;
	logic [REG_W-1:0]    shamt;
	logic [IMM_W-1:0]    imm16;
	logic                legal;

	assign opcode = inst_i[OPCODE_POS +: OPCODE_W];
	assign funct  = inst_i[FUNCT_POS +: FUNCT_W];
	assign rs     = inst_i[RS_POS +: REG_W];
	assign rt     = inst_i[RT_POS +: REG_W];
	assign rd     = inst_i[RD_POS +: REG_W];
	assign shamt  = inst_i[SHAMT_POS +: REG_W];
	assign imm16  = inst_i[IMM_POS +: IMM_W];

	assign illegal_o = !legal;

	always_comb begin
		aluop_o     = ALU_NOP;
		reg1_read_o = 1'b0;
		reg2_read_o = 1'b0;
		wreg_o      = 1'b0;
		wd_o        = rd;
		imm_o       = '0;
		legal       = 1'b1;
		case (opcode)
			OP_SPECIAL: begin
				reg1_read_o = 1'b1;
				reg2_read_o = 1'b1;
				wreg_o      = 1'b1;
				legal       = (shamt == '0);
				case (funct)
					FN_SLL, FN_SLLV: aluop_o = ALU_SLL;
					FN_SRL, FN_SRLV: aluop_o = ALU_SRL;
					FN_SRA, FN_SRAV: aluop_o = ALU_SRA;
					FN_AND:  aluop_o = ALU_AND;
					FN_OR:   aluop_o = ALU_OR;
					FN_XOR:  aluop_o = ALU_XOR;
					FN_NOR:  aluop_o = ALU_NOR;
					FN_ADD:  aluop_o = ALU_ADD;
					FN_ADDU: aluop_o = ALU_ADDU;
					FN_SUB:  aluop_o = ALU_SUB;
					FN_SUBU: aluop_o = ALU_SUBU;
					FN_SLT:  aluop_o = ALU_SLT;
					FN_SLTU: aluop_o = ALU_SLTU;
					FN_JR:   aluop_o = ALU_JR;
					FN_JALR: aluop_o = ALU_JALR;
					default: legal = 1'b0;
				endcase
				case (funct)
					FN_SLL, FN_SRL, FN_SRA: begin
						reg1_read_o = 1'b0; // shift amount comes in as reg1
						imm_o       = word_t'(shamt);
						legal       = (rs == '0);
					end
					FN_JR, FN_JALR: begin
						reg2_read_o = 1'b0;
						wreg_o      = (funct == FN_JALR);
					end
					default: begin
					end
				endcase
			end
			OP_REGIMM: begin
				reg1_read_o = 1'b1;
				case (rt)
					RI_BLTZ:   aluop_o = ALU_BLTZ;
					RI_BGEZ:   aluop_o = ALU_BGEZ;
					RI_BLTZAL: aluop_o = ALU_BLTZAL;
					RI_BGEZAL: aluop_o = ALU_BGEZAL;
					default:   legal = 1'b0;
				endcase
				if (rt == RI_BLTZAL || rt == RI_BGEZAL) begin
					wreg_o = 1'b1; // gated by taken in decode_ctrl
					wd_o   = LINK_REG;
				end
			end
			OP_J: aluop_o = ALU_J;
			OP_JAL: begin
				aluop_o = ALU_JAL;
				wreg_o  = 1'b1;
				wd_o    = LINK_REG;
			end
			OP_BEQ, OP_BNE: begin
				aluop_o     = (opcode == OP_BEQ) ? ALU_BEQ : ALU_BNE;
				reg1_read_o = 1'b1;
				reg2_read_o = 1'b1;
			end
			OP_BLEZ, OP_BGTZ: begin
				aluop_o     = (opcode == OP_BLEZ) ? ALU_BLEZ : ALU_BGTZ;
				reg1_read_o = 1'b1;
			end
			OP_LW: begin
				aluop_o     = ALU_LW;
				reg1_read_o = 1'b1;
				wreg_o      = 1'b1;
				wd_o        = rt;
			end
			OP_SW: begin
				aluop_o     = ALU_SW;
				reg1_read_o = 1'b1;
				reg2_read_o = 1'b1;
			end
			OP_ANDI, OP_ORI, OP_XORI, OP_LUI, OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU: begin
				reg1_read_o = 1'b1;
				wreg_o      = 1'b1;
				wd_o        = rt;
				case (opcode)
					OP_ANDI:  aluop_o = ALU_AND;
					OP_XORI:  aluop_o = ALU_XOR;
					OP_ADDI:  aluop_o = ALU_ADDI;
					OP_ADDIU: aluop_o = ALU_ADDIU;
					OP_SLTI:  aluop_o = ALU_SLT;
					OP_SLTIU: aluop_o = ALU_SLTU;
					default:  aluop_o = ALU_OR; // ori and lui
				endcase
				case (opcode)
					OP_ANDI, OP_ORI, OP_XORI: imm_o = {{IMM_W{1'b0}}, imm16};
					OP_LUI: imm_o = {imm16, {IMM_W{1'b0}}};
					default: imm_o = {{(WORD_W-IMM_W){imm16[IMM_W-1]}}, imm16};
				endcase
			end
			default: legal = 1'b0;
		endcase
		if (!legal) begin
			aluop_o     = ALU_NOP; // issue as nop
			reg1_read_o = 1'b0;
			reg2_read_o = 1'b0;
			wreg_o      = 1'b0;
			imm_o       = '0;
		end
	end

	always_comb begin
		case (aluop_o)
			ALU_NOP: alusel_o = SEL_NOP;
			ALU_AND, ALU_OR, ALU_XOR, ALU_NOR: alusel_o = SEL_LOGIC;
			ALU_SLL, ALU_SRL, ALU_SRA: alusel_o = SEL_SHIFT;
			ALU_ADD, ALU_ADDU, ALU_SUB, ALU_SUBU, ALU_ADDI, ALU_ADDIU,
			ALU_SLT, ALU_SLTU: alusel_o = SEL_ARITH;
			ALU_LW, ALU_SW: alusel_o = SEL_LOAD_STORE;
			default: alusel_o = SEL_JUMP_BRANCH;
		endcase
	end

endmodule

`default_nettype wire

// ==== operand_fwd.sv ====
`default_nettype none

module operand_fwd (
	input  wire                         read_i,
	input  wire                         ex_load_i,
	input  wire                         ex_wreg_i,
	input  wire                         mem_wreg_i,
	input  var mips_isa_pkg::reg_addr_t addr_i,
	input  var mips_isa_pkg::reg_addr_t ex_wd_i,
	input  var mips_isa_pkg::reg_addr_t mem_wd_i,
	input  var mips_isa_pkg::word_t     rf_data_i,
	input  var mips_isa_pkg::word_t     imm_i,
	input  var mips_isa_pkg::word_t     ex_wdata_i,
	input  var mips_isa_pkg::word_t     mem_wdata_i,
	output mips_isa_pkg::word_t         data_o,
	output logic                        hazard_o
);

	logic ex_hit;
	logic mem_hit;

	assign ex_hit  = ex_wreg_i && (ex_wd_i == addr_i);
	assign mem_hit = mem_wreg_i && (mem_wd_i == addr_i);

	// load result not ready until mem
	assign hazard_o = read_i && ex_load_i && (ex_wd_i == addr_i);

	always_comb begin
		if (!read_i) begin
			data_o = imm_i;
		end else if (ex_hit) begin
			data_o = ex_wdata_i; // newest first
		end else if (mem_hit) begin
			data_o = mem_wdata_i;
		end else begin
			data_o = rf_data_i;
		end
	end

endmodule

`default_nettype wire

// ==== branch_unit.sv ====
`default_nettype none

module branch_unit (
	input  var id_pkg::alu_op_e     aluop_i,
	input  var mips_isa_pkg::word_t pc_i,
	input  var mips_isa_pkg::word_t inst_i,
	input  var mips_isa_pkg::word_t reg1_i,
	input  var mips_isa_pkg::word_t reg2_i,
	output logic                    taken_o,
	output mips_isa_pkg::word_t     target_o,
	output mips_isa_pkg::word_t     link_addr_o
);
	import mips_isa_pkg::*;
	import id_pkg::*;

	word_t pc_plus4;
	word_t pc_plus8;
	word_t br_offset;
	word_t jmp_target;
	logic  reg1_neg;
	logic  reg1_zero;

	assign pc_plus4   = pc_i + 32'd4;
	assign pc_plus8   = pc_i + 32'd8;
	assign br_offset  = {{(WORD_W-IMM_W-2){inst_i[IMM_POS+IMM_W-1]}},
		inst_i[IMM_POS +: IMM_W], 2'b00};
	assign jmp_target = {pc_plus4[WORD_W-1 -: 4], inst_i[INDEX_POS +: INDEX_W], 2'b00};
	assign reg1_neg   = reg1_i[WORD_W-1];
	assign reg1_zero  = (reg1_i == '0);

	always_comb begin
		taken_o     = 1'b1;
		target_o    = pc_plus4 + br_offset;
		link_addr_o = '0;
		case (aluop_i)
			ALU_J: target_o = jmp_target;
			ALU_JAL: begin
				target_o    = jmp_target;
				link_addr_o = pc_plus8; // skip the delay slot
			end
			ALU_JR: target_o = reg1_i;
			ALU_JALR: begin
				target_o    = reg1_i;
				link_addr_o = pc_plus8;
			end
			ALU_BEQ:  taken_o = (reg1_i == reg2_i);
			ALU_BNE:  taken_o = (reg1_i != reg2_i);
			ALU_BGTZ: taken_o = !reg1_neg && !reg1_zero;
			ALU_BLEZ: taken_o = reg1_neg || reg1_zero;
			ALU_BGEZ: taken_o = !reg1_neg;
			ALU_BLTZ: taken_o = reg1_neg;
			ALU_BGEZAL: begin
				taken_o     = !reg1_neg;
				link_addr_o = pc_plus8;
			end
			ALU_BLTZAL: begin
				taken_o     = reg1_neg;
				link_addr_o = pc_plus8;
			end
			default: taken_o = 1'b0;
		endcase
		if (!taken_o) begin
			target_o = '0;
		end
	end

endmodule

`default_nettype wire

// ==== decode_ctrl.sv ====
`default_nettype none

module decode_ctrl (
	input  wire                         clk,
	input  wire                         rst_n_i,
	input  wire                         in_valid_i,
	input  wire                         out_ready_i,
	input  wire                         hazard1_i,
	input  wire                         hazard2_i,
	input  wire                         wreg_i,
	input  wire                         taken_i,
	input  wire                         illegal_i,
	input  var id_pkg::alu_op_e         ex_aluop_i,
	input  var id_pkg::alu_op_e         aluop_i,
	input  var id_pkg::alu_sel_e        alusel_i,
	input  var mips_isa_pkg::reg_addr_t wd_i,
	input  var mips_isa_pkg::word_t     reg1_i,
	input  var mips_isa_pkg::word_t     reg2_i,
	input  var mips_isa_pkg::word_t     link_addr_i,
	input  var mips_isa_pkg::word_t     target_i,
	output logic                        in_ready_o,
	output logic                        ex_load_o,
	output logic                        out_valid_o,
	output id_pkg::alu_op_e             out_aluop_o,
	output id_pkg::alu_sel_e            out_alusel_o,
	output mips_isa_pkg::word_t         out_reg1_o,
	output mips_isa_pkg::word_t         out_reg2_o,
	output mips_isa_pkg::reg_addr_t     out_wd_o,
	output logic                        out_wreg_o,
	output mips_isa_pkg::word_t         out_link_addr_o,
	output logic                        out_in_delayslot_o,
	output logic                        out_illegal_o,
	output logic                        out_branch_taken_o,
	output mips_isa_pkg::word_t         out_branch_target_o
);
	import id_pkg::*;

	logic take;
	logic ds_pending; // last loaded instruction was a taken jump/branch
	logic link_branch;

	assign ex_load_o   = is_load(ex_aluop_i);
	assign in_ready_o  = (!out_valid_o || out_ready_i) && !hazard1_i && !hazard2_i;
	assign take        = in_valid_i && in_ready_o;
	assign link_branch = (aluop_i == ALU_BGEZAL) || (aluop_i == ALU_BLTZAL);

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			out_valid_o <= 1'b0;
			ds_pending  <= 1'b0;
		end else if (take) begin
			out_valid_o <= 1'b1;
			ds_pending  <= taken_i;
		end else if (out_ready_i) begin
			out_valid_o <= 1'b0; // drained, nothing new
		end
	end

	always_ff @(posedge clk) begin
		if (take) begin
			out_aluop_o         <= aluop_i;
			out_alusel_o        <= alusel_i;
			out_reg1_o          <= reg1_i;
			out_reg2_o          <= reg2_i;
			out_wd_o            <= wd_i;
			out_wreg_o          <= link_branch ? taken_i : wreg_i;
			out_link_addr_o     <= link_addr_i;
			out_in_delayslot_o  <= ds_pending;
			out_illegal_o       <= illegal_i;
			out_branch_taken_o  <= taken_i;
			out_branch_target_o <= target_i;
		end
	end

endmodule

`default_nettype wire

// ==== id_stage.sv ====
`default_nettype none

module id_stage (
	input  wire                         clk,
	input  wire                         rst_n_i,
	input  wire                         in_valid_i,
	input  var mips_isa_pkg::word_t     in_pc_i,
	input  var mips_isa_pkg::word_t     in_inst_i,
	output logic                        in_ready_o,
	output mips_isa_pkg::reg_addr_t     rf_raddr1_o,
	output mips_isa_pkg::reg_addr_t     rf_raddr2_o,
	input  var mips_isa_pkg::word_t     rf_rdata1_i,
	input  var mips_isa_pkg::word_t     rf_rdata2_i,
	input  wire                         ex_wreg_i,
	input  var mips_isa_pkg::reg_addr_t ex_wd_i,
	input  var mips_isa_pkg::word_t     ex_wdata_i,
	input  var id_pkg::alu_op_e         ex_aluop_i,
	input  wire                         mem_wreg_i,
	input  var mips_isa_pkg::reg_addr_t mem_wd_i,
	input  var mips_isa_pkg::word_t     mem_wdata_i,
	output logic                        out_valid_o,
	input  wire                         out_ready_i,
	output id_pkg::alu_op_e             out_aluop_o,
	output id_pkg::alu_sel_e            out_alusel_o,
	output mips_isa_pkg::word_t         out_reg1_o,
	output mips_isa_pkg::word_t         out_reg2_o,
	output mips_isa_pkg::reg_addr_t     out_wd_o,
	output logic                        out_wreg_o,
	output mips_isa_pkg::word_t         out_link_addr_o,
	output logic                        out_in_delayslot_o,
	output logic                        out_illegal_o,
	output logic                        out_branch_taken_o,
	output mips_isa_pkg::word_t         out_branch_target_o
);
	import mips_isa_pkg::*;
	import id_pkg::*;

	alu_op_e   dec_aluop;
	alu_sel_e  dec_alusel;
	logic      dec_reg1_read;
	logic      dec_reg2_read;
	logic      dec_wreg;
	logic      dec_illegal;
	reg_addr_t dec_wd;
	word_t     dec_imm;
	word_t     reg1;
	word_t     reg2;
	logic      hazard1;
	logic      hazard2;
	logic      ex_load;
	logic      br_taken;
	word_t     br_target;
	word_t     br_link;

	assign rf_raddr1_o = in_inst_i[RS_POS +: REG_W];
	assign rf_raddr2_o = in_inst_i[RT_POS +: REG_W];

	inst_decoder u_dec (
		.inst_i      (in_inst_i),
		.aluop_o     (dec_aluop),
		.alusel_o    (dec_alusel),
		.reg1_read_o (dec_reg1_read),
		.reg2_read_o (dec_reg2_read),
		.wreg_o      (dec_wreg),
		.illegal_o   (dec_illegal),
		.wd_o        (dec_wd),
		.imm_o       (dec_imm)
	);

	operand_fwd fwd1 (
		.read_i (dec_reg1_read), .ex_load_i (ex_load),
		.ex_wreg_i (ex_wreg_i), .mem_wreg_i (mem_wreg_i),
		.addr_i (rf_raddr1_o), .ex_wd_i (ex_wd_i), .mem_wd_i (mem_wd_i),
		.rf_data_i (rf_rdata1_i), .imm_i (dec_imm),
		.ex_wdata_i (ex_wdata_i), .mem_wdata_i (mem_wdata_i),
		.data_o (reg1), .hazard_o (hazard1)
	);

	operand_fwd fwd2 (
		.read_i (dec_reg2_read), .ex_load_i (ex_load),
		.ex_wreg_i (ex_wreg_i), .mem_wreg_i (mem_wreg_i),
		.addr_i (rf_raddr2_o), .ex_wd_i (ex_wd_i), .mem_wd_i (mem_wd_i),
		.rf_data_i (rf_rdata2_i), .imm_i (dec_imm),
		.ex_wdata_i (ex_wdata_i), .mem_wdata_i (mem_wdata_i),
		.data_o (reg2), .hazard_o (hazard2)
	);

	branch_unit u_br (
		.aluop_i     (dec_aluop),
		.pc_i        (in_pc_i),
		.inst_i      (in_inst_i),
		.reg1_i      (reg1),
		.reg2_i      (reg2),
		.taken_o     (br_taken),
		.target_o    (br_target),
		.link_addr_o (br_link)
	);

	decode_ctrl u_ctrl (
		.clk (clk), .rst_n_i (rst_n_i),
		.in_valid_i (in_valid_i), .out_ready_i (out_ready_i),
		.hazard1_i (hazard1), .hazard2_i (hazard2),
		.wreg_i (dec_wreg), .taken_i (br_taken), .illegal_i (dec_illegal),
		.ex_aluop_i (ex_aluop_i), .aluop_i (dec_aluop), .alusel_i (dec_alusel),
		.wd_i (dec_wd), .reg1_i (reg1), .reg2_i (reg2),
		.link_addr_i (br_link), .target_i (br_target),
		.in_ready_o (in_ready_o), .ex_load_o (ex_load),
		.out_valid_o (out_valid_o), .out_aluop_o (out_aluop_o),
		.out_alusel_o (out_alusel_o), .out_reg1_o (out_reg1_o),
		.out_reg2_o (out_reg2_o), .out_wd_o (out_wd_o),
		.out_wreg_o (out_wreg_o), .out_link_addr_o (out_link_addr_o),
		.out_in_delayslot_o (out_in_delayslot_o), .out_illegal_o (out_illegal_o),
		.out_branch_taken_o (out_branch_taken_o),
		.out_branch_target_o (out_branch_target_o)
	);

endmodule

`default_nettype wire

// ==== id_stage_assert.sv ====
`default_nettype none

module id_stage_assert (
	input wire        clk,
	input wire        rst_n_i,
	input wire        in_valid_i,
	input wire        in_ready_o,
	input wire        out_valid_o,
	input wire        out_ready_i,
	input wire [7:0]  out_aluop_o,
	input wire [31:0] out_reg1_o,
	input wire [31:0] out_reg2_o,
	input wire [31:0] out_branch_target_o,
	input wire [7:0]  ex_aluop_i,
	input wire [4:0]  ex_wd_i,
	input wire [4:0]  rf_raddr1_o,
	input wire [4:0]  rf_raddr2_o,
	input wire        dec_reg1_read,
	input wire        dec_reg2_read
);
	import id_pkg::*;

	logic load_hit;

	// pending load into a source that is read
	assign load_hit = (ex_aluop_i == ALU_LW) &&
		((dec_reg1_read && ex_wd_i == rf_raddr1_o) ||
		(dec_reg2_read && ex_wd_i == rf_raddr2_o));

	a_reset_quiet: assert property (@(posedge clk) !rst_n_i |-> !out_valid_o)
		else $error("out_valid_o high during reset");

	// nothing shows up on the outputs before something is taken
	a_valid_after_take: assert property (@(posedge clk) disable iff (!rst_n_i)
		!out_valid_o && !(in_valid_i && in_ready_o) |=> !out_valid_o)
		else $error("out_valid_o rose with no instruction taken");

	// held result must not move while stalled
	a_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
		out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_aluop_o)
		&& $stable(out_reg1_o) && $stable(out_reg2_o) && $stable(out_branch_target_o))
		else $error("outputs changed under back-pressure");

	a_no_take_on_hazard: assert property (@(posedge clk) disable iff (!rst_n_i)
		load_hit |-> !(in_valid_i && in_ready_o))
		else $error("instruction taken during load-use hazard");

endmodule

bind id_stage id_stage_assert u_assert (
	.clk (clk), .rst_n_i (rst_n_i), .in_valid_i (in_valid_i), .in_ready_o (in_ready_o),
	.out_valid_o (out_valid_o), .out_ready_i (out_ready_i), .out_aluop_o (out_aluop_o),
	.out_reg1_o (out_reg1_o), .out_reg2_o (out_reg2_o),
	.out_branch_target_o (out_branch_target_o), .ex_aluop_i (ex_aluop_i),
	.ex_wd_i (ex_wd_i), .rf_raddr1_o (rf_raddr1_o), .rf_raddr2_o (rf_raddr2_o),
	.dec_reg1_read (dec_reg1_read), .dec_reg2_read (dec_reg2_read)
);

`default_nettype wire

// ==== tb_id_stage.sv ====
`default_nettype none

module tb_id_stage;
	import mips_isa_pkg::*;
	import id_pkg::*;

	typedef struct packed {
		alu_op_e   aluop;
		alu_sel_e  alusel;
		word_t     reg1;
		word_t     reg2;
		reg_addr_t wd;
		logic      wreg;
		word_t     link;
		logic      ds;
		logic      illegal;
		logic      taken;
		word_t     target;
	} exp_t;

	localparam int WAIT_LIMIT = 200;

	logic      clk = 1'b0;
	logic      rst_n_i;
	logic      in_valid;
	word_t     in_pc;
	word_t     in_inst;
	logic      in_ready_o;
	reg_addr_t rf_raddr1;
	reg_addr_t rf_raddr2;
	word_t     rf_rdata1;
	word_t     rf_rdata2;
	logic      ex_wreg;
	reg_addr_t ex_wd;
	word_t     ex_wdata;
	alu_op_e   ex_aluop;
	logic      mem_wreg;
	reg_addr_t mem_wd;
	word_t     mem_wdata;
	logic      out_ready = 1'b1;
	logic      out_valid_o;
	alu_op_e   out_aluop_o;
	alu_sel_e  out_alusel_o;
	word_t     out_reg1_o;
	word_t     out_reg2_o;
	reg_addr_t out_wd_o;
	logic      out_wreg_o;
	word_t     out_link_addr_o;
	logic      out_in_delayslot_o;
	logic      out_illegal_o;
	logic      out_branch_taken_o;
	word_t     out_branch_target_o;

	word_t rf [32];
	exp_t  exp_q [$];
	int    seed;
	int    ready_seed;
	int    errors = 0;
	int    checks = 0;
	logic  ready_random = 1'b0;
	logic  ds_flag = 1'b0;
	logic  expect_valid = 1'b0;
	logic  timed_out = 1'b0;
	string test_name = "reset";

	always #2 clk = !clk;

	assign rf_rdata1 = rf[rf_raddr1];
	assign rf_rdata2 = rf[rf_raddr2];

	id_stage uut (
		.clk (clk), .rst_n_i (rst_n_i),
		.in_valid_i (in_valid), .in_pc_i (in_pc), .in_inst_i (in_inst),
		.in_ready_o (in_ready_o),
		.rf_raddr1_o (rf_raddr1), .rf_raddr2_o (rf_raddr2),
		.rf_rdata1_i (rf_rdata1), .rf_rdata2_i (rf_rdata2),
		.ex_wreg_i (ex_wreg), .ex_wd_i (ex_wd), .ex_wdata_i (ex_wdata), .ex_aluop_i (ex_aluop),
		.mem_wreg_i (mem_wreg), .mem_wd_i (mem_wd), .mem_wdata_i (mem_wdata),
		.out_valid_o (out_valid_o), .out_ready_i (out_ready),
		.out_aluop_o (out_aluop_o), .out_alusel_o (out_alusel_o),
		.out_reg1_o (out_reg1_o), .out_reg2_o (out_reg2_o),
		.out_wd_o (out_wd_o), .out_wreg_o (out_wreg_o),
		.out_link_addr_o (out_link_addr_o), .out_in_delayslot_o (out_in_delayslot_o),
		.out_illegal_o (out_illegal_o), .out_branch_taken_o (out_branch_taken_o),
		.out_branch_target_o (out_branch_target_o)
	);

	task automatic check(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		checks++;
		if (expected !== actual) begin
			errors++;
			$display("ERROR %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	function automatic word_t pick_operand(logic rd_en, reg_addr_t a, word_t imm);
		if (!rd_en) return imm;
		if (ex_wreg && ex_wd == a) return ex_wdata; // newest writer wins
		if (mem_wreg && mem_wd == a) return mem_wdata;
		return rf[a];
	endfunction

	function automatic exp_t predict(word_t inst, word_t pc, logic ds);
		exp_t      e;
		logic [5:0] op;
		logic [5:0] fn;
		reg_addr_t rs;
		reg_addr_t rt;
		logic [4:0] sh;
		logic [15:0] i16;
		logic      r1;
		logic      r2;
		logic      legal;
		word_t     imm;
		word_t     p4;
		op = inst[31:26];
		fn = inst[5:0];
		rs = inst[25:21];
		rt = inst[20:16];
		sh = inst[10:6];
		i16 = inst[15:0];
		e = '0;
		e.aluop = ALU_NOP;
		e.wd = inst[15:11];
		r1 = 1'b0;
		r2 = 1'b0;
		legal = 1'b1;
		imm = '0;
		case (op)
			OP_SPECIAL: begin
				r1 = 1'b1;
				r2 = 1'b1;
				e.wreg = 1'b1;
				legal = (sh == 0);
				case (fn)
					FN_SLL, FN_SRL, FN_SRA: begin
						r1 = 1'b0;
						imm = {27'b0, sh};
						legal = (rs == 0); // shamt is used here
						e.aluop = (fn == FN_SLL) ? ALU_SLL : (fn == FN_SRL) ? ALU_SRL : ALU_SRA;
					end
					FN_SLLV: e.aluop = ALU_SLL;
					FN_SRLV: e.aluop = ALU_SRL;
					FN_SRAV: e.aluop = ALU_SRA;
					FN_AND:  e.aluop = ALU_AND;
					FN_OR:   e.aluop = ALU_OR;
					FN_XOR:  e.aluop = ALU_XOR;
					FN_NOR:  e.aluop = ALU_NOR;
					FN_ADD:  e.aluop = ALU_ADD;
					FN_ADDU: e.aluop = ALU_ADDU;
					FN_SUB:  e.aluop = ALU_SUB;
					FN_SUBU: e.aluop = ALU_SUBU;
					FN_SLT:  e.aluop = ALU_SLT;
					FN_SLTU: e.aluop = ALU_SLTU;
					FN_JR: begin
						e.aluop = ALU_JR;
						r2 = 1'b0;
						e.wreg = 1'b0;
					end
					FN_JALR: begin
						e.aluop = ALU_JALR;
						r2 = 1'b0;
					end
					default: legal = 1'b0;
				endcase
			end
			OP_REGIMM: begin
				r1 = 1'b1;
				case (rt)
					RI_BLTZ: e.aluop = ALU_BLTZ;
					RI_BGEZ: e.aluop = ALU_BGEZ;
					RI_BLTZAL, RI_BGEZAL: begin
						e.aluop = (rt == RI_BLTZAL) ? ALU_BLTZAL : ALU_BGEZAL;
						e.wd = LINK_REG;
					end
					default: legal = 1'b0;
				endcase
			end
			OP_J: e.aluop = ALU_J;
			OP_JAL: begin
				e.aluop = ALU_JAL;
				e.wreg = 1'b1;
				e.wd = LINK_REG;
			end
			OP_BEQ, OP_BNE: begin
				e.aluop = (op == OP_BEQ) ? ALU_BEQ : ALU_BNE;
				r1 = 1'b1;
				r2 = 1'b1;
			end
			OP_BLEZ, OP_BGTZ: begin
				e.aluop = (op == OP_BLEZ) ? ALU_BLEZ : ALU_BGTZ;
				r1 = 1'b1;
			end
			OP_LW: begin
				e.aluop = ALU_LW;
				r1 = 1'b1;
				e.wreg = 1'b1;
				e.wd = rt;
			end
			OP_SW: begin
				e.aluop = ALU_SW;
				r1 = 1'b1;
				r2 = 1'b1;
			end
			OP_ANDI: e.aluop = ALU_AND;
			OP_ORI, OP_LUI: e.aluop = ALU_OR;
			OP_XORI: e.aluop = ALU_XOR;
			OP_ADDI: e.aluop = ALU_ADDI;
			OP_ADDIU: e.aluop = ALU_ADDIU;
			OP_SLTI: e.aluop = ALU_SLT;
			OP_SLTIU: e.aluop = ALU_SLTU;
			default: legal = 1'b0;
		endcase
		if (op[5:3] == 3'b001) begin // immediate group writes rt
			r1 = 1'b1;
			e.wreg = 1'b1;
			e.wd = rt;
			if (op == OP_LUI) begin
				imm = {i16, 16'b0};
			end else if (op[2]) begin
				imm = {16'b0, i16}; // andi, ori, xori
			end else begin
				imm = {{16{i16[15]}}, i16};
			end
		end
		if (!legal) begin
			e.aluop = ALU_NOP;
			r1 = 1'b0;
			r2 = 1'b0;
			e.wreg = 1'b0;
			imm = '0;
		end
		e.illegal = !legal;
		e.reg1 = pick_operand(r1, rs, imm);
		e.reg2 = pick_operand(r2, rt, imm);
		p4 = pc + 32'd4;
		e.target = p4 + {{14{i16[15]}}, i16, 2'b00};
		case (e.aluop)
			ALU_J, ALU_JAL: begin
				e.taken = 1'b1;
				e.target = {p4[31:28], inst[25:0], 2'b00};
			end
			ALU_JR, ALU_JALR: begin
				e.taken = 1'b1;
				e.target = e.reg1;
			end
			ALU_BEQ: e.taken = (e.reg1 == e.reg2);
			ALU_BNE: e.taken = (e.reg1 != e.reg2);
			ALU_BGTZ: e.taken = ($signed(e.reg1) > 0);
			ALU_BLEZ: e.taken = ($signed(e.reg1) <= 0);
			ALU_BGEZ, ALU_BGEZAL: e.taken = !e.reg1[31];
			ALU_BLTZ, ALU_BLTZAL: e.taken = e.reg1[31];
			default: e.taken = 1'b0;
		endcase
		if (!e.taken) e.target = '0;
		if (e.aluop inside {ALU_JAL, ALU_JALR, ALU_BGEZAL, ALU_BLTZAL}) e.link = pc + 32'd8;
		if (e.aluop inside {ALU_BGEZAL, ALU_BLTZAL}) e.wreg = e.taken;
		case (e.aluop)
			ALU_NOP: e.alusel = SEL_NOP;
			ALU_AND, ALU_OR, ALU_XOR, ALU_NOR: e.alusel = SEL_LOGIC;
			ALU_SLL, ALU_SRL, ALU_SRA: e.alusel = SEL_SHIFT;
			ALU_LW, ALU_SW: e.alusel = SEL_LOAD_STORE;
			ALU_ADD, ALU_ADDU, ALU_SUB, ALU_SUBU, ALU_ADDI, ALU_ADDIU,
			ALU_SLT, ALU_SLTU: e.alusel = SEL_ARITH;
			default: e.alusel = SEL_JUMP_BRANCH;
		endcase
		e.ds = ds;
		return e;
	endfunction

	task automatic compare_result(input exp_t e);
		check({test_name, " aluop"}, e.aluop, out_aluop_o);
		check({test_name, " alusel"}, e.alusel, out_alusel_o);
		check({test_name, " reg1"}, e.reg1, out_reg1_o);
		check({test_name, " reg2"}, e.reg2, out_reg2_o);
		check({test_name, " wd"}, e.wd, out_wd_o);
		check({test_name, " wreg"}, e.wreg, out_wreg_o);
		check({test_name, " link"}, e.link, out_link_addr_o);
		check({test_name, " delayslot"}, e.ds, out_in_delayslot_o);
		check({test_name, " illegal"}, e.illegal, out_illegal_o);
		check({test_name, " taken"}, e.taken, out_branch_taken_o);
		check({test_name, " target"}, e.target, out_branch_target_o);
	endtask

	// scoreboard sees the values from before this edge
	always @(posedge clk) begin
		exp_t e;
		if (!rst_n_i) begin
			ds_flag = 1'b0;
			expect_valid = 1'b0;
		end else begin
			if (expect_valid) check({test_name, " latency"}, 1, out_valid_o);
			expect_valid = 1'b0;
			if (out_valid_o && out_ready) begin
				if (exp_q.size() == 0) begin
					errors++;
					$display("output transfer with no instruction pending");
				end else begin
					e = exp_q.pop_front();
					compare_result(e);
				end
			end
			if (in_valid && in_ready_o) begin
				check({test_name, " raddr1"}, in_inst[25:21], rf_raddr1);
				check({test_name, " raddr2"}, in_inst[20:16], rf_raddr2);
				e = predict(in_inst, in_pc, ds_flag);
				ds_flag = e.taken;
				exp_q.push_back(e);
				expect_valid = 1'b1;
			end
		end
	end

	always @(posedge clk) begin
		int rnd;
		rnd = $random(ready_seed);
		out_ready <= ready_random ? (rnd[0] | rnd[1]) : 1'b1;
	end

	task automatic rand_reg(output reg_addr_t r);
		int rnd;
		rnd = $random(seed);
		r = reg_addr_t'(rnd[2:0]); // small range for more hits
	endtask

	task automatic set_bypass;
		int rnd;
		reg_addr_t r;
		rnd = $random(seed);
		ex_wreg <= rnd[0];
		mem_wreg <= rnd[1];
		ex_aluop <= ALU_ADD;
		rand_reg(r);
		ex_wd <= r;
		rand_reg(r);
		mem_wd <= r;
		ex_wdata <= $random(seed);
		mem_wdata <= $random(seed);
	endtask

	task automatic gen_inst(input int kind, output word_t inst);
		logic [5:0] fn_list [16];
		reg_addr_t  rs;
		reg_addr_t  rt;
		reg_addr_t  rd;
		int         rnd;
		fn_list = '{FN_SLL, FN_SRL, FN_SRA, FN_SLLV, FN_SRLV, FN_SRAV, FN_AND, FN_OR,
			FN_XOR, FN_NOR, FN_ADD, FN_ADDU, FN_SUB, FN_SUBU, FN_SLT, FN_SLTU};
		rand_reg(rs);
		rand_reg(rt);
		rand_reg(rd);
		rnd = $random(seed);
		inst = $random(seed);
		case (kind)
			0: begin
				inst = {OP_SPECIAL, rs, rt, rd, 5'd0, fn_list[rnd[7:4]]};
				if (inst[5:0] inside {FN_SLL, FN_SRL, FN_SRA}) begin
					inst = {11'b0, rt, rd, rnd[12:8], inst[5:0]};
				end
			end
			1: inst = {3'b001, rnd[2:0], rs, rt, rnd[31:16]};
			2: inst = {rnd[0] ? OP_LW : OP_SW, rs, rt, rnd[31:16]};
			3: inst = {4'b0001, rnd[1:0], rs, rnd[2] ? rs : rt, rnd[31:16]}; // beq/bne/blez/bgtz
			4: inst = {OP_REGIMM, rs, rnd[1], 3'b000, rnd[0], rnd[31:16]};
			5: begin
				if (rnd[1]) inst = {5'b00001, rnd[0], inst[25:0]};
				else inst = {OP_SPECIAL, rs, 5'd0, rd, 5'd0, 5'b00100, rnd[0]};
			end
			default: begin
			end
		endcase
	endtask

	task automatic wait_take;
		int t;
		t = 0;
		@(posedge clk);
		while (!in_ready_o && t < WAIT_LIMIT) begin
			@(posedge clk);
			t++;
		end
		if (!in_ready_o) begin
			timed_out = 1'b1;
			errors++;
			$display("timeout waiting for the stage to accept an instruction");
		end
	endtask

	task automatic send(input word_t inst);
		in_valid <= 1'b1;
		in_inst <= inst;
		in_pc <= {$random(seed)} & 32'hffff_fffc;
		wait_take();
	endtask

	task automatic run_random(input string name, input int n, input int lo, input int hi);
		word_t inst;
		int    rnd;
		test_name = name;
		for (int i = 0; i < n && !timed_out; i++) begin
			rnd = $random(seed);
			gen_inst(lo + ({rnd} % (hi - lo + 1)), inst);
			set_bypass();
			send(inst);
			if (rnd[30] && ready_random) begin
				in_valid <= 1'b0; // idle gap
				@(posedge clk);
			end
		end
	endtask

	task automatic load_use(input reg_addr_t src, input bit on_rt);
		word_t inst;
		test_name = "load_use";
		inst = {OP_SPECIAL, on_rt ? 5'd4 : src, on_rt ? src : 5'd4, 5'd9, 5'd0, FN_ADD};
		set_bypass();
		ex_aluop <= ALU_LW;
		ex_wd <= src;
		in_valid <= 1'b1;
		in_inst <= inst;
		in_pc <= 32'h0000_1000;
		repeat (4) begin
			@(posedge clk);
			check("load_use stall", 0, in_ready_o);
		end
		ex_aluop <= ALU_ADD; // load moved on
		wait_take();
	endtask

	initial begin
		int t;
		seed = 32'h6aa2;
		ready_seed = seed ^ 32'h5a5a;
		rst_n_i = 1'b0;
		in_valid = 1'b0;
		in_pc = '0;
		in_inst = '0;
		ex_wreg = 1'b0;
		ex_wd = '0;
		ex_wdata = '0;
		ex_aluop = ALU_NOP;
		mem_wreg = 1'b0;
		mem_wd = '0;
		mem_wdata = '0;
		for (int i = 0; i < 32; i++) begin
			rf[i] = (i == 0) ? '0 : ($random(seed) ^ (i * 32'h0101_0101));
		end
		repeat (5) @(posedge clk);
		rst_n_i <= 1'b1;
		@(posedge clk);
		check("reset out_valid", 0, out_valid_o);
		check("reset in_ready", 1, in_ready_o);
		run_random("alu_decode", 80, 0, 2);
		run_random("forwarding", 40, 0, 1);
		for (int i = 1; i < 5 && !timed_out; i++) begin
			load_use(reg_addr_t'(i), i[0]);
		end
		run_random("branch", 80, 3, 5);
		ready_random = 1'b1;
		run_random("backpressure", 150, 0, 6);
		in_valid <= 1'b0;
		ready_random = 1'b0;
		t = 0;
		while (exp_q.size() != 0 && t < WAIT_LIMIT) begin
			@(posedge clk);
			t++;
		end
		if (exp_q.size() != 0) begin
			errors++;
			$display("timeout draining the stage, results missing");
		end
		@(posedge clk);
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== src.f ====
mips_isa_pkg.sv
id_pkg.sv
inst_decoder.sv
operand_fwd.sv
branch_unit.sv
decode_ctrl.sv
id_stage.sv
id_stage_assert.sv
tb_id_stage.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --assert -Wno-fatal -f src.f --top-module tb_id_stage -o sim_id_stage
./obj_dir/sim_id_stage > sim.log 2>&1
cat sim.log

if grep -q "TEST FAILED" sim.log; then
	exit 1
fi
exit 0
